// ==== all.f ====
+incdir+logic
logic/ppu_cfg_pkg.sv
logic/cfg_sync.sv
logic/video_mode_select.sv
logic/scanline_cfg.sv
logic/ppu_state_collect.sv
logic/ppu_cfg_top.sv
testbench/ppu_cfg_assertions.sv
testbench/tb_ppu_cfg.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert --top-module tb_ppu_cfg -f all.f
	./obj_dir/Vtb_ppu_cfg > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Something failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== testbench/tb_ppu_cfg.sv ====
// ==========================================================
// directed tests, reference models and compare tasks
// for the config and status front end
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module tb_ppu_cfg
  import ppu_cfg_pkg::*;
();

  localparam int WAIT_LIMIT = 16;

  logic                 n64_clk;
  logic                 arst_n;
  cfg_word_t            config_word;
  vinfo_t               vinfo;
  logic                 scaler_nresync;
  vmode_t               vmode;
  logic                 active_vsync;
  logic                 active_hsync;
  sl_set_t              vsl;
  sl_set_t              hsl;
  logic [`INTERP_W-1:0] v_interp;
  logic [`INTERP_W-1:0] h_interp;
  logic                 sl_per_channel;
  ppu_state_t           ppu_state;
  logic                 scaler_nrst;
  logic [31:0]          lcg_state;
  int                   mismatches;
  int                   timeouts;

  ppu_cfg_top dut (
    .N64_CLK_i       (n64_clk),
    .arst_n_i        (arst_n),
    .config_word_i   (config_word),
    .vinfo_i         (vinfo),
    .scaler_nresync_i(scaler_nresync),
    .vmode_o         (vmode),
    .active_vsync_o  (active_vsync),
    .active_hsync_o  (active_hsync),
    .vsl_o           (vsl),
    .hsl_o           (hsl),
    .v_interp_o      (v_interp),
    .h_interp_o      (h_interp),
    .sl_per_channel_o(sl_per_channel),
    .ppu_state_o     (ppu_state),
    .scaler_nrst_o   (scaler_nrst)
  );

  bind ppu_cfg_top ppu_cfg_assertions asrt (
    .N64_CLK_i       (N64_CLK_i),
    .arst_n_i        (arst_n_i),
    .cfg_s_i         (cfg_s),
    .hsl_i           (hsl_o),
    .vsl_i           (vsl_o),
    .v_interp_i      (v_interp_o),
    .h_interp_i      (h_interp_o),
    .scaler_nresync_i(scaler_nresync_i),
    .scaler_nrst_i   (scaler_nrst_o)
  );

  initial begin
    n64_clk = 1'b0;
    forever #20 n64_clk = ~n64_clk;
  end

  // ========================================================
  // reference models
  // ========================================================

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic vmode_id_t expected_mode(input logic [2:0] tgt, input logic vga);
    case (tgt)
      `TGT_480P:   return vga ? VMODE_VGA : VMODE_480P;
      `TGT_720P:   return VMODE_720P;
      `TGT_960P:   return VMODE_960P;
      `TGT_1080P:  return VMODE_1080P;
      `TGT_1200P:  return VMODE_1200P;
      `TGT_1440P:  return VMODE_1440P;
      `TGT_1440WP: return VMODE_1440WP;
      default:     return VMODE_240P;
    endcase
  endfunction

  function automatic logic expected_50hz(input logic f60, input logic f50, input logic llm,
                                         input logic is240, input logic pal);
    if (llm || is240) begin
      return pal;
    end
    if (f60) begin
      return 1'b0;
    end
    return f50 ? 1'b1 : pal;
  endfunction

  function automatic sl_set_t expected_sl(input logic en, input logic [1:0] thick,
                                          input logic [1:0] prof, input logic [3:0] s);
    sl_set_t r;
    r.en        = en;
    r.thickness = thick;
    r.profile   = prof;
    r.strength  = 8'((int'(s) + 1) * 16 - 1);
    return r;
  endfunction

  // ========================================================
  // compare tasks
  // ========================================================

  task automatic check_vmode(input string name, input vmode_t got, input vmode_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_sl(input string name, input sl_set_t got, input sl_set_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_state(input string name, input ppu_state_t got, input ppu_state_t exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_interp(input string name, input logic [`INTERP_W-1:0] got,
                              input logic [`INTERP_W-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ========================================================
  // stimulus helpers
  // ========================================================

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge n64_clk);
    end
  endtask

  // drive on the falling edge, settle past the 3 cycle latency
  task automatic apply_inputs(input cfg_word_t c, input vinfo_t v);
    @(negedge n64_clk);
    config_word = c;
    vinfo       = v;
    wait_cycles(4);
  endtask

  task automatic expect_pulse(input string what, input vinfo_t v);
    int n;
    @(negedge n64_clk);
    vinfo = v;
    @(negedge n64_clk);
    n = 1;
    while (scaler_nrst && n < WAIT_LIMIT) begin
      @(negedge n64_clk);
      n++;
    end
    if (scaler_nrst) begin
      timeouts++;
      $display("scaler_nrst_o never went low after the %s change", what);
    end else begin
      if (n != 4) begin
        mismatches++;
        $display("[FAIL] %0t scaler_nrst_o delay got %0d expected 4", $time, n);
      end
      wait_cycles(1);
      check_bit("scaler_nrst_o", scaler_nrst, 1'b1);
    end
    wait_cycles(4);
  endtask

  // ========================================================
  // directed tests
  // ========================================================

  task automatic test_reset();
    // still inside reset here
    check_vmode("vmode_o", vmode, '0);
    check_bit("active_vsync_o", active_vsync, 1'b0);
    check_bit("active_hsync_o", active_hsync, 1'b0);
    check_sl("vsl_o", vsl, '0);
    check_sl("hsl_o", hsl, '0);
    check_interp("v_interp_o", v_interp, '0);
    check_interp("h_interp_o", h_interp, '0);
    check_bit("sl_per_channel_o", sl_per_channel, 1'b0);
    check_state("ppu_state_o", ppu_state, '0);
    check_bit("scaler_nrst_o", scaler_nrst, 1'b0);
    arst_n = 1'b1;
    wait_cycles(1);
    check_bit("scaler_nrst_o", scaler_nrst, 1'b1);
  endtask

  task automatic test_mode_table();
    cfg_word_t c;
    vmode_t    vx;
    logic      hd;
    for (int code = 0; code < 8; code++) begin
      for (int vga = 0; vga < 2; vga++) begin
        c  = {28'd0, vga[0], code[2:0]};
        apply_inputs(c, vinfo);
        vx.id      = expected_mode(code[2:0], vga[0]);
        vx.is_50hz = 1'b0;
        hd = !(vx.id inside {VMODE_240P, VMODE_480P, VMODE_VGA});
        check_vmode("vmode_o", vmode, vx);
        check_bit("active_vsync_o", active_vsync, hd);
        check_bit("active_hsync_o", active_hsync, hd);
      end
    end
  endtask

  task automatic test_50hz();
    cfg_word_t c;
    vinfo_t    v;
    vmode_t    vx;
    for (int k = 0; k < 32; k++) begin
      c              = '0;
      c[`FORCE60]    = k[0];
      c[`FORCE50]    = k[1];
      c[`LLM]        = k[2];
      c[`TGT_RES]    = k[3] ? `TGT_240P : `TGT_1080P;
      v              = '0;
      v.vdata_detected = 1'b1;
      v.palmode      = k[4];
      apply_inputs(c, v);
      vx.id      = k[3] ? VMODE_240P : VMODE_1080P;
      vx.is_50hz = expected_50hz(k[0], k[1], k[2], k[3], k[4]);
      check_vmode("vmode_o", vmode, vx);
    end
  endtask

  task automatic test_scanlines();
    cfg_word_t c;
    sl_set_t   hx;
    sl_set_t   vx;
    logic      is240;
    for (int i = 0; i < 48; i++) begin
      c = next_rand();
      if (i % 4 == 0) begin
        c[`TGT_RES] = `TGT_240P;
      end
      apply_inputs(c, vinfo);
      is240 = (c[`TGT_RES] == `TGT_240P);
      hx = expected_sl(c[`HSL_EN], c[`HSL_THICK], c[`HSL_PROF], c[`HSL_STR]);
      if (c[`H2V_LINKED]) begin
        vx = expected_sl(c[`VSL_EN], c[`HSL_THICK], c[`HSL_PROF], c[`HSL_STR]);
      end else begin
        vx = expected_sl(c[`VSL_EN], c[`VSL_THICK], c[`VSL_PROF], c[`VSL_STR]);
      end
      check_sl("hsl_o", hsl, hx);
      check_sl("vsl_o", vsl, vx);
      check_interp("v_interp_o", v_interp, is240 ? 2'b00 : c[`V_INTERP]);
      check_interp("h_interp_o", h_interp, is240 ? 2'b00 : c[`H_INTERP]);
      check_bit("sl_per_channel_o", sl_per_channel, c[`SL_PER_CH]);
    end
  endtask

  task automatic test_status();
    cfg_word_t   c;
    vinfo_t      v;
    ppu_state_t  sx;
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
      c = next_rand();
      r = next_rand();
      v = r[31:29];
      apply_inputs(c, v);
      sx.vdata_detected = v.vdata_detected;
      sx.palmode        = v.palmode;
      sx.interlaced     = v.n64_480i;
      sx.force50        = c[`FORCE50];
      sx.force60        = c[`FORCE60];
      sx.vga480p        = c[`VGA480P];
      sx.resolution     = c[`TGT_RES];
      sx.llm            = c[`LLM];
      sx.pal_boxed      = c[`PAL_BOXED];
      sx.sl_per_channel = c[`SL_PER_CH];
      check_state("ppu_state_o", ppu_state, sx);
    end
  endtask

  task automatic test_scaler_reset();
    vinfo_t v;
    v = vinfo;
    // let any pulse from earlier tests pass
    wait_cycles(6);
    v.palmode = ~v.palmode;
    expect_pulse("palmode", v);
    v.vdata_detected = ~v.vdata_detected;
    expect_pulse("vdata_detected", v);
    @(negedge n64_clk);
    scaler_nresync = 1'b0;
    for (int i = 0; i < 6; i++) begin
      @(negedge n64_clk);
      check_bit("scaler_nrst_o", scaler_nrst, 1'b0);
    end
    scaler_nresync = 1'b1;
    wait_cycles(1);
    check_bit("scaler_nrst_o", scaler_nrst, 1'b1);
  endtask

  initial begin
    mismatches     = 0;
    timeouts       = 0;
    lcg_state      = 32'h83b;
    arst_n         = 1'b0;
    config_word    = '0;
    vinfo          = '0;
    scaler_nresync = 1'b1;
    wait_cycles(5);
    test_reset();
    test_mode_table();
    test_50hz();
    test_scanlines();
    test_status();
    test_scaler_reset();
    $display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== testbench/ppu_cfg_assertions.sv ====
// ==========================================================
// concurrent checks bound into the front end top level
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module ppu_cfg_assertions
  import ppu_cfg_pkg::*;
(
  input logic                 N64_CLK_i,
  input logic                 arst_n_i,
  input cfg_word_t            cfg_s_i,
  input sl_set_t              hsl_i,
  input sl_set_t              vsl_i,
  input logic [`INTERP_W-1:0] v_interp_i,
  input logic [`INTERP_W-1:0] h_interp_i,
  input logic                 scaler_nresync_i,
  input logic                 scaler_nrst_i
);

  // expanded strength always ends in a full nibble
  str_nibble_a: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    1'b1 |=> (hsl_i.strength[3:0] == 4'hf && vsl_i.strength[3:0] == 4'hf))
    else $error("scanline strength low nibble is not all ones");

  // no interpolation in 240p
  interp_240p_a: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    (cfg_s_i[`TGT_RES] == `TGT_240P) |=> (v_interp_i == '0 && h_interp_i == '0))
    else $error("interpolation mode set while target is 240p");

  // change pulse is a single cycle
  nrst_pulse_a: assert property (@(posedge N64_CLK_i) disable iff (!arst_n_i)
    (!scaler_nrst_i && scaler_nresync_i) |=> (scaler_nrst_i || !scaler_nresync_i))
    else $error("scaler reset low for two cycles without a resync request");

endmodule

// ==== logic/ppu_cfg_top.sv ====
// ==========================================================
// config and status front end, top level
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module ppu_cfg_top
  import ppu_cfg_pkg::*;
(
  input  logic                 N64_CLK_i,
  input  logic                 arst_n_i,

  // asynchronous inputs
  input  cfg_word_t            config_word_i,
  input  vinfo_t               vinfo_i,
  input  logic                 scaler_nresync_i,

  // output mode
  output vmode_t               vmode_o,
  output logic                 active_vsync_o,
  output logic                 active_hsync_o,

  // scanlines and interpolation
  output sl_set_t              vsl_o,
  output sl_set_t              hsl_o,
  output logic [`INTERP_W-1:0] v_interp_o,
  output logic [`INTERP_W-1:0] h_interp_o,
  output logic                 sl_per_channel_o,

  // status and scaler control
  output ppu_state_t           ppu_state_o,
  output logic                 scaler_nrst_o
);

  cfg_word_t cfg_s;
  vinfo_t    vinfo_s;

  // ========================================================
  // synchronizers
  // ========================================================

  cfg_sync #(
    .payload_t(cfg_word_t)
  ) sync_cfg (
    .N64_CLK_i(N64_CLK_i),
    .arst_n_i (arst_n_i),
    .d_i      (config_word_i),
    .q_o      (cfg_s)
  );

  cfg_sync #(
    .payload_t(vinfo_t)
  ) sync_vinfo (
    .N64_CLK_i(N64_CLK_i),
    .arst_n_i (arst_n_i),
    .d_i      (vinfo_i),
    .q_o      (vinfo_s)
  );

  // ========================================================
  // resolvers
  // ========================================================

  video_mode_select mode_select_u (
    .N64_CLK_i     (N64_CLK_i),
    .arst_n_i      (arst_n_i),
    .cfg_i         (cfg_s),
    .palmode_i     (vinfo_s.palmode),
    .vmode_o       (vmode_o),
    .active_vsync_o(active_vsync_o),
    .active_hsync_o(active_hsync_o)
  );

  scanline_cfg scanline_u (
    .N64_CLK_i       (N64_CLK_i),
    .arst_n_i        (arst_n_i),
    .cfg_i           (cfg_s),
    .vsl_o           (vsl_o),
    .hsl_o           (hsl_o),
    .v_interp_o      (v_interp_o),
    .h_interp_o      (h_interp_o),
    .sl_per_channel_o(sl_per_channel_o)
  );

  ppu_state_collect state_u (
    .N64_CLK_i       (N64_CLK_i),
    .arst_n_i        (arst_n_i),
    .cfg_i           (cfg_s),
    .vinfo_i         (vinfo_s),
    .scaler_nresync_i(scaler_nresync_i),
    .ppu_state_o     (ppu_state_o),
    .scaler_nrst_o   (scaler_nrst_o)
  );

endmodule

// ==== logic/ppu_state_collect.sv ====
// ==========================================================
// status word for the CPU and scaler reset generation
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module ppu_state_collect
  import ppu_cfg_pkg::*;
(
  input  logic       N64_CLK_i,
  input  logic       arst_n_i,
  input  cfg_word_t  cfg_i,
  input  vinfo_t     vinfo_i,
  input  logic       scaler_nresync_i,
  output ppu_state_t ppu_state_o,
  output logic       scaler_nrst_o
);

  ppu_state_t state_d;
  logic [1:0] palmode_hist;
  logic [1:0] vdet_hist;
  logic       n_pal_change;
  logic       n_vdet_change;

  // ========================================================
  // status word
  // ========================================================

  always_comb begin
    state_d.vdata_detected = vinfo_i.vdata_detected;
    state_d.palmode        = vinfo_i.palmode;
    state_d.interlaced     = vinfo_i.n64_480i;
    state_d.force50        = cfg_i[`FORCE50];
    state_d.force60        = cfg_i[`FORCE60];
    state_d.vga480p        = cfg_i[`VGA480P];
    state_d.resolution     = cfg_i[`TGT_RES];
    state_d.llm            = cfg_i[`LLM];
    state_d.pal_boxed      = cfg_i[`PAL_BOXED];
    state_d.sl_per_channel = cfg_i[`SL_PER_CH];
  end

  // ========================================================
  // scaler reset on source format change
  // ========================================================

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ppu_state_o   <= '0;
      palmode_hist  <= '0;
      vdet_hist     <= '0;
      // held low in reset, released on the first edge after
      n_pal_change  <= 1'b0;
      n_vdet_change <= 1'b0;
    end else begin
      ppu_state_o   <= state_d;
      palmode_hist  <= {palmode_hist[0], vinfo_i.palmode};
      vdet_hist     <= {vdet_hist[0], vinfo_i.vdata_detected};
      n_pal_change  <= ~^palmode_hist;
      n_vdet_change <= ~^vdet_hist;
    end
  end

  // resync request acts without a clock
  assign scaler_nrst_o = n_pal_change & n_vdet_change & scaler_nresync_i;

endmodule

// ==== logic/scanline_cfg.sv ====
// ==========================================================
// scanline sets and interpolation modes
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module scanline_cfg
  import ppu_cfg_pkg::*;
(
  input  logic                 N64_CLK_i,
  input  logic                 arst_n_i,
  input  cfg_word_t            cfg_i,
  output sl_set_t              vsl_o,
  output sl_set_t              hsl_o,
  output logic [`INTERP_W-1:0] v_interp_o,
  output logic [`INTERP_W-1:0] h_interp_o,
  output logic                 sl_per_channel_o
);

  // (s+1)*16-1 is just s with a low nibble of ones
  function automatic logic [`SL_STR_EXP_W-1:0] expand_str(input logic [`SL_STR_W-1:0] s);
    return {s, 4'hf};
  endfunction

  sl_set_t hsl_d;
  sl_set_t vsl_d;
  logic    tgt_240p;

  assign tgt_240p = (cfg_i[`TGT_RES] == `TGT_240P);

  always_comb begin
    hsl_d.en        = cfg_i[`HSL_EN];
    hsl_d.thickness = cfg_i[`HSL_THICK];
    hsl_d.profile   = cfg_i[`HSL_PROF];
    hsl_d.strength  = expand_str(cfg_i[`HSL_STR]);

    // enable stays per direction even when linked
    vsl_d.en = cfg_i[`VSL_EN];
    if (cfg_i[`H2V_LINKED]) begin
      vsl_d.thickness = hsl_d.thickness;
      vsl_d.profile   = hsl_d.profile;
      vsl_d.strength  = hsl_d.strength;
    end else begin
      vsl_d.thickness = cfg_i[`VSL_THICK];
      vsl_d.profile   = cfg_i[`VSL_PROF];
      vsl_d.strength  = expand_str(cfg_i[`VSL_STR]);
    end
  end

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hsl_o            <= '0;
      vsl_o            <= '0;
      v_interp_o       <= '0;
      h_interp_o       <= '0;
      sl_per_channel_o <= 1'b0;
    end else begin
      hsl_o            <= hsl_d;
      vsl_o            <= vsl_d;
      // 240p is passed through unscaled
      v_interp_o       <= tgt_240p ? '0 : cfg_i[`V_INTERP];
      h_interp_o       <= tgt_240p ? '0 : cfg_i[`H_INTERP];
      sl_per_channel_o <= cfg_i[`SL_PER_CH];
    end
  end

endmodule

// ==== logic/video_mode_select.sv ====
// ==========================================================
// output video mode, 50 Hz flag and sync polarity
// ==========================================================

`timescale 1ns/1ps
`include "ppu_cfg_cfg.svh"

module video_mode_select
  import ppu_cfg_pkg::*;
(
  input  logic      N64_CLK_i,
  input  logic      arst_n_i,
  input  cfg_word_t cfg_i,
  input  logic      palmode_i,
  output vmode_t    vmode_o,
  output logic      active_vsync_o,
  output logic      active_hsync_o
);

  logic [`TGT_W-1:0] tgt;
  vmode_id_t         mode_id;
  logic              is_50hz;
  logic              hd_sync;

  assign tgt = cfg_i[`TGT_RES];

  // ========================================================
  // mode id from the target code
  // ========================================================

  always_comb begin
    case (tgt)
      `TGT_240P:   mode_id = VMODE_240P;
      `TGT_720P:   mode_id = VMODE_720P;
      `TGT_960P:   mode_id = VMODE_960P;
      `TGT_1080P:  mode_id = VMODE_1080P;
      `TGT_1200P:  mode_id = VMODE_1200P;
      `TGT_1440P:  mode_id = VMODE_1440P;
      `TGT_1440WP: mode_id = VMODE_1440WP;
      // 480p slot doubles as VGA
      `TGT_480P:   mode_id = cfg_i[`VGA480P] ? VMODE_VGA : VMODE_480P;
      default:     mode_id = VMODE_480P;
    endcase
  end

  // ========================================================
  // 50 Hz flag
  // ========================================================

  always_comb begin
    if (cfg_i[`LLM] || (tgt == `TGT_240P)) begin
      // no frame rate conversion possible here, follow the source
      is_50hz = palmode_i;
    end else if (cfg_i[`FORCE60]) begin
      is_50hz = 1'b0;
    end else if (cfg_i[`FORCE50]) begin
      is_50hz = 1'b1;
    end else begin
      is_50hz = palmode_i;
    end
  end

  // HD timings use positive sync
  assign hd_sync = (mode_id >= VMODE_720P);

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vmode_o.id      <= VMODE_240P;
      vmode_o.is_50hz <= 1'b0;
      active_vsync_o  <= 1'b0;
      active_hsync_o  <= 1'b0;
    end else begin
      vmode_o.id      <= mode_id;
      vmode_o.is_50hz <= is_50hz;
      active_vsync_o  <= hd_sync;
      active_hsync_o  <= hd_sync;
    end
  end

endmodule

// ==== logic/cfg_sync.sv ====
// ==========================================================
// two-flop synchronizer for an arbitrary payload type
// ==========================================================

`timescale 1ns/1ps

module cfg_sync #(
  parameter type payload_t = logic
) (
  input  logic     N64_CLK_i,
  input  logic     arst_n_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // first stage may go metastable, only q_o is used downstream
  payload_t meta_q;

  always_ff @(posedge N64_CLK_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= '0;
      q_o    <= '0;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

// ==== logic/ppu_cfg_pkg.sv ====
// ==========================================================
// types shared by the config and status front end
// ==========================================================

`include "ppu_cfg_cfg.svh"

package ppu_cfg_pkg;

  // raw configuration word as written by the CPU
  typedef logic [`PPU_CFG_W-1:0] cfg_word_t;

  // video info from the input-side detector
  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic n64_480i;
  } vinfo_t;

  // output modes, ordered so that 720P and up are the HD modes
  typedef enum logic [3:0] {
    VMODE_240P   = 4'd0,
    VMODE_480P   = 4'd1,
    VMODE_VGA    = 4'd2,
    VMODE_720P   = 4'd3,
    VMODE_960P   = 4'd4,
    VMODE_1080P  = 4'd5,
    VMODE_1200P  = 4'd6,
    VMODE_1440P  = 4'd7,
    VMODE_1440WP = 4'd8
  } vmode_id_t;

  typedef struct packed {
    vmode_id_t id;
    logic      is_50hz;
  } vmode_t;

  // one scanline direction
  typedef struct packed {
    logic                       en;
    logic [`SL_THICK_W-1:0]     thickness;
    logic [`SL_PROF_W-1:0]      profile;
    logic [`SL_STR_EXP_W-1:0]   strength;
  } sl_set_t;

  // status word read back by the CPU
  typedef struct packed {
    logic              vdata_detected;
    logic              palmode;
    logic              interlaced;
    logic              force50;
    logic              force60;
    logic              vga480p;
    logic [`TGT_W-1:0] resolution;
    logic              llm;
    logic              pal_boxed;
    logic              sl_per_channel;
  } ppu_state_t;

endpackage

// ==== logic/ppu_cfg_cfg.svh ====
// ==========================================================
// config word layout, field widths and target resolution
// codes of the post-processing front end
// ==========================================================

`ifndef PPU_CFG_CFG_SVH
`define PPU_CFG_CFG_SVH

`define PPU_CFG_W 32

// field widths
`define TGT_W        3
`define INTERP_W     2
`define SL_THICK_W   2
`define SL_PROF_W    2
`define SL_STR_W     4
`define SL_STR_EXP_W 8

// config word bit positions
`define TGT_RES    2:0
`define VGA480P    3
`define FORCE60    4
`define FORCE50    5
`define LLM        6
`define PAL_BOXED  7
`define V_INTERP   9:8
`define H_INTERP   11:10
`define HSL_EN     12
`define VSL_EN     13
`define H2V_LINKED 14
`define SL_PER_CH  15
`define HSL_THICK  17:16
`define HSL_PROF   19:18
`define HSL_STR    23:20
`define VSL_THICK  25:24
`define VSL_PROF   27:26
`define VSL_STR    31:28

// target resolution codes
`define TGT_480P   3'd0
`define TGT_720P   3'd1
`define TGT_960P   3'd2
`define TGT_1080P  3'd3
`define TGT_1200P  3'd4
`define TGT_1440P  3'd5
`define TGT_1440WP 3'd6
`define TGT_240P   3'd7

`endif
